/* trace_macros.svh */
`ifndef TRACE_MACROS_SVH
`define TRACE_MACROS_SVH

// Records held in the trace FIFO
`define TRACE_FIFO_DEPTH 8

// Credits held after reset match the sink buffer
`define TRACE_CREDITS 4

// Local data-memory address width
`define TRACE_LADDR_W 10

// Width of the saturating stall counter
`define TRACE_STALLCNT_W 8

`endif

/* trace_pkg.sv */
`default_nettype none

`include "trace_macros.svh"

package trace_pkg;

  // Reason for the most recent stall
  typedef enum logic [2:0] {
    STALL_NONE,
    STALL_IFETCH,
    STALL_IDIV,
    STALL_LOAD,
    STALL_OTHER
  } stall_code_e;

  typedef enum logic [2:0] {
    ACC_NONE,
    ACC_LLOAD,
    ACC_LSTORE,
    ACC_RLOAD,
    ACC_RSTORE
  } access_kind_e;

  typedef struct packed {
    logic [31-`TRACE_LADDR_W:0] pad;
    logic [`TRACE_LADDR_W-1:0]  addr;
    logic [31:0]                data;
  } local_view_s;

  // Remote load leaves data at zero
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } remote_view_s;

  // View picked by the access kind
  typedef union packed {
    local_view_s  lcl;
    remote_view_s rmt;
  } mem_access_u;

  typedef struct packed {
    logic [31:0]                  pc;
    logic [31:0]                  instr;
    access_kind_e                 kind;
    mem_access_u                  mem;
    logic                         rf_wen;
    logic [4:0]                   rf_waddr;
    logic [31:0]                  rf_wdata;
    stall_code_e                  stall_code;
    logic [`TRACE_STALLCNT_W-1:0] stall_cycles;
  } trace_rec_s;

endpackage

`default_nettype wire

/* wb_stage_if.sv */
`timescale 1ns/10ps
`default_nettype none

// Debug view of the instruction in writeback
interface wb_stage_if;
  import trace_pkg::*;

  logic         wb_v;
  logic [31:0]  pc;
  logic [31:0]  instr;
  access_kind_e kind;
  mem_access_u  mem;

  modport source (output wb_v, output pc, output instr, output kind, output mem);

  modport sink (input wb_v, input pc, input instr, input kind, input mem);

endinterface

`default_nettype wire

/* trace_stage_pipe.sv */
`timescale 1ns/10ps
`default_nettype none

`include "trace_macros.svh"

module trace_stage_pipe (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      stall_all_i,
  input  logic                      exe_v_i,
  input  logic [31:0]               exe_pc_i,
  input  logic [31:0]               exe_instr_i,
  input  logic                      lsu_v_i,
  input  logic                      lsu_w_i,
  input  logic [`TRACE_LADDR_W-1:0] lsu_addr_i,
  input  logic [31:0]               lsu_data_i,
  input  logic [31:0]               load_data_i,
  input  logic                      remote_v_i,
  input  logic                      remote_w_i,
  input  logic [31:0]               remote_addr_i,
  input  logic [31:0]               remote_data_i,
  wb_stage_if.source                wb_o
);
  import trace_pkg::*;

  access_kind_e exe_kind;
  mem_access_u  exe_mem;

  logic         mem_v_r;
  logic [31:0]  mem_pc_r;
  logic [31:0]  mem_instr_r;
  access_kind_e mem_kind_r;
  mem_access_u  mem_acc_r;
  mem_access_u  mem_acc_wb;

  logic         wb_v_r;
  logic [31:0]  wb_pc_r;
  logic [31:0]  wb_instr_r;
  access_kind_e wb_kind_r;
  mem_access_u  wb_acc_r;

  // Local access wins over remote
  always_comb begin
    exe_kind = ACC_NONE;
    exe_mem  = '0;
    if (exe_v_i && lsu_v_i) begin
      exe_kind         = lsu_w_i ? ACC_LSTORE : ACC_LLOAD;
      exe_mem.lcl.addr = lsu_addr_i;
      exe_mem.lcl.data = lsu_data_i;
    end else if (exe_v_i && remote_v_i) begin
      exe_kind         = remote_w_i ? ACC_RSTORE : ACC_RLOAD;
      exe_mem.rmt.addr = remote_addr_i;
      exe_mem.rmt.data = remote_w_i ? remote_data_i : 32'h0;
    end
  end

  // Load data shows up in the memory stage
  always_comb begin
    mem_acc_wb = mem_acc_r;
    if (mem_kind_r == ACC_LLOAD) begin
      mem_acc_wb.lcl.data = load_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_v_r <= 1'b0;
      wb_v_r  <= 1'b0;
    end else if (!stall_all_i) begin
      mem_v_r <= exe_v_i;
      wb_v_r  <= mem_v_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_all_i) begin
      mem_pc_r    <= exe_pc_i;
      mem_instr_r <= exe_instr_i;
      mem_kind_r  <= exe_kind;
      mem_acc_r   <= exe_mem;
      wb_pc_r     <= mem_pc_r;
      wb_instr_r  <= mem_instr_r;
      wb_kind_r   <= mem_kind_r;
      wb_acc_r    <= mem_acc_wb;
    end
  end

  assign wb_o.wb_v  = wb_v_r;
  assign wb_o.pc    = wb_pc_r;
  assign wb_o.instr = wb_instr_r;
  assign wb_o.kind  = wb_kind_r;
  assign wb_o.mem   = wb_acc_r;

endmodule

`default_nettype wire

/* trace_encoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "trace_macros.svh"

module trace_encoder (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               trace_en_i,
  input  logic               stall_all_i,
  input  logic               stall_ifetch_i,
  input  logic               stall_idiv_i,
  input  logic               stall_load_i,
  input  logic               rf_wen_i,
  input  logic [4:0]         rf_waddr_i,
  input  logic [31:0]        rf_wdata_i,
  wb_stage_if.sink           wb_i,
  output logic               push_o,
  output trace_pkg::trace_rec_s rec_o
);
  import trace_pkg::*;

  localparam logic [`TRACE_STALLCNT_W-1:0] STALL_MAX = '1;

  logic                         retire;
  logic [`TRACE_STALLCNT_W-1:0] stall_cnt_r;
  stall_code_e                  stall_code_r;
  stall_code_e                  stall_code_n;

  assign retire = wb_i.wb_v && !stall_all_i && trace_en_i;

  always_comb begin
    if (stall_ifetch_i) begin
      stall_code_n = STALL_IFETCH;
    end else if (stall_idiv_i) begin
      stall_code_n = STALL_IDIV;
    end else if (stall_load_i) begin
      stall_code_n = STALL_LOAD;
    end else begin
      stall_code_n = STALL_OTHER;
    end
  end

  // Retire and stall never share a cycle
  always_ff @(posedge clk_i) begin
    if (reset_i || retire) begin
      stall_cnt_r  <= '0;
      stall_code_r <= STALL_NONE;
    end else if (stall_all_i) begin
      if (stall_cnt_r != STALL_MAX) begin
        stall_cnt_r <= stall_cnt_r + 1'b1;
      end
      stall_code_r <= stall_code_n;
    end
  end

  assign push_o = retire;

  always_comb begin
    rec_o.pc           = wb_i.pc;
    rec_o.instr        = wb_i.instr;
    rec_o.kind         = wb_i.kind;
    rec_o.mem          = wb_i.mem;
    rec_o.rf_wen       = rf_wen_i;
    rec_o.rf_waddr     = rf_waddr_i;
    rec_o.rf_wdata     = rf_wdata_i;
    rec_o.stall_code   = stall_code_r;
    rec_o.stall_cycles = stall_cnt_r;
  end

endmodule

`default_nettype wire

/* trace_fifo_credit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "trace_macros.svh"

module trace_fifo_credit (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  push_i,
  input  trace_pkg::trace_rec_s rec_i,
  input  logic                  credit_return_i,
  output logic                  trace_v_o,
  output trace_pkg::trace_rec_s trace_rec_o,
  output logic                  overflow_o
);
  import trace_pkg::*;

  localparam int DEPTH  = `TRACE_FIFO_DEPTH;
  localparam int PTR_W  = $clog2(DEPTH);
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int CRED_W = $clog2(`TRACE_CREDITS + 1);

  trace_rec_s        buf_r [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_r;
  logic [PTR_W-1:0]  rd_ptr_r;
  logic [CNT_W-1:0]  count_r;
  logic [CRED_W-1:0] credit_r;
  logic [CRED_W-1:0] credit_n;
  logic              full;
  logic              wr_en;
  logic              launch;

  assign full  = (count_r == CNT_W'(DEPTH));
  assign wr_en = push_i && !full;

  // Credits left once this cycle's record is counted
  assign credit_n = credit_r - CRED_W'(trace_v_o) + CRED_W'(credit_return_i);
  assign launch   = (count_r != '0) && (credit_n != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r   <= '0;
      rd_ptr_r   <= '0;
      count_r    <= '0;
      credit_r   <= CRED_W'(`TRACE_CREDITS);
      trace_v_o  <= 1'b0;
      overflow_o <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (launch) begin
        rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      count_r    <= count_r + CNT_W'(wr_en) - CNT_W'(launch);
      credit_r   <= credit_n;
      trace_v_o  <= launch;
      // Sticky until reset
      overflow_o <= overflow_o || (push_i && full);
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      buf_r[wr_ptr_r] <= rec_i;
    end
    if (launch) begin
      trace_rec_o <= buf_r[rd_ptr_r];
    end
  end

endmodule

`default_nettype wire

/* core_trace_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "trace_macros.svh"

module core_trace_top (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      exe_v_i,
  input  logic [31:0]               exe_pc_i,
  input  logic [31:0]               exe_instr_i,
  input  logic                      lsu_v_i,
  input  logic                      lsu_w_i,
  input  logic [`TRACE_LADDR_W-1:0] lsu_addr_i,
  input  logic [31:0]               lsu_data_i,
  input  logic [31:0]               load_data_i,
  input  logic                      remote_v_i,
  input  logic                      remote_w_i,
  input  logic [31:0]               remote_addr_i,
  input  logic [31:0]               remote_data_i,
  input  logic                      rf_wen_i,
  input  logic [4:0]                rf_waddr_i,
  input  logic [31:0]               rf_wdata_i,
  input  logic                      stall_all_i,
  input  logic                      stall_ifetch_i,
  input  logic                      stall_idiv_i,
  input  logic                      stall_load_i,
  input  logic                      trace_en_i,
  input  logic                      credit_return_i,
  output logic                      trace_v_o,
  output trace_pkg::trace_rec_s     trace_rec_o,
  output logic                      trace_overflow_o
);
  import trace_pkg::*;

  logic       push;
  trace_rec_s rec;

  wb_stage_if wb_if ();

  trace_stage_pipe u_pipe (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .stall_all_i   (stall_all_i),
    .exe_v_i       (exe_v_i),
    .exe_pc_i      (exe_pc_i),
    .exe_instr_i   (exe_instr_i),
    .lsu_v_i       (lsu_v_i),
    .lsu_w_i       (lsu_w_i),
    .lsu_addr_i    (lsu_addr_i),
    .lsu_data_i    (lsu_data_i),
    .load_data_i   (load_data_i),
    .remote_v_i    (remote_v_i),
    .remote_w_i    (remote_w_i),
    .remote_addr_i (remote_addr_i),
    .remote_data_i (remote_data_i),
    .wb_o          (wb_if.source)
  );

  trace_encoder u_enc (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .trace_en_i     (trace_en_i),
    .stall_all_i    (stall_all_i),
    .stall_ifetch_i (stall_ifetch_i),
    .stall_idiv_i   (stall_idiv_i),
    .stall_load_i   (stall_load_i),
    .rf_wen_i       (rf_wen_i),
    .rf_waddr_i     (rf_waddr_i),
    .rf_wdata_i     (rf_wdata_i),
    .wb_i           (wb_if.sink),
    .push_o         (push),
    .rec_o          (rec)
  );

  trace_fifo_credit u_fifo (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .push_i          (push),
    .rec_i           (rec),
    .credit_return_i (credit_return_i),
    .trace_v_o       (trace_v_o),
    .trace_rec_o     (trace_rec_o),
    .overflow_o      (trace_overflow_o)
  );

endmodule

`default_nettype wire

/* tb_clkgen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic reset_o
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

/* tb_trace_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_trace_checker (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  trace_v_i,
  input  trace_pkg::trace_rec_s trace_rec_i,
  input  logic                  exp_v_i,
  input  trace_pkg::trace_rec_s exp_rec_i,
  output int                    err_cnt_o,
  output int                    seen_cnt_o,
  output int                    pending_o
);
  import trace_pkg::*;

  trace_rec_s exp_q[$];
  trace_rec_s head;
  int         errs = 0;
  int         seen = 0;
  int         pend = 0;

  assign err_cnt_o  = errs;
  assign seen_cnt_o = seen;
  assign pending_o  = pend;

  task automatic check_field(input string name, input logic [63:0] exp_val,
                             input logic [63:0] got_val);
    if (exp_val !== got_val) begin
      $display("MISMATCH trace_rec_o.%s: expected 0x%0h, got 0x%0h", name, exp_val, got_val);
      errs++;
    end
  endtask

  task automatic compare_rec(input trace_rec_s e, input trace_rec_s g);
    check_field("pc", 64'(e.pc), 64'(g.pc));
    check_field("instr", 64'(e.instr), 64'(g.instr));
    check_field("kind", 64'(e.kind), 64'(g.kind));
    // Union is read through the view the kind selects
    case (e.kind)
      ACC_LLOAD, ACC_LSTORE: begin
        check_field("mem.lcl.pad", 64'(e.mem.lcl.pad), 64'(g.mem.lcl.pad));
        check_field("mem.lcl.addr", 64'(e.mem.lcl.addr), 64'(g.mem.lcl.addr));
        check_field("mem.lcl.data", 64'(e.mem.lcl.data), 64'(g.mem.lcl.data));
      end
      ACC_RLOAD, ACC_RSTORE: begin
        check_field("mem.rmt.addr", 64'(e.mem.rmt.addr), 64'(g.mem.rmt.addr));
        check_field("mem.rmt.data", 64'(e.mem.rmt.data), 64'(g.mem.rmt.data));
      end
      default: check_field("mem", 64'(e.mem), 64'(g.mem));
    endcase
    check_field("rf_wen", 64'(e.rf_wen), 64'(g.rf_wen));
    check_field("rf_waddr", 64'(e.rf_waddr), 64'(g.rf_waddr));
    check_field("rf_wdata", 64'(e.rf_wdata), 64'(g.rf_wdata));
    check_field("stall_code", 64'(e.stall_code), 64'(g.stall_code));
    check_field("stall_cycles", 64'(e.stall_cycles), 64'(g.stall_cycles));
  endtask

  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (exp_v_i) begin
        exp_q.push_back(exp_rec_i);
      end
      if (trace_v_i) begin
        if (exp_q.size() == 0) begin
          $display("unexpected record with pc 0x%0h while none is pending", trace_rec_i.pc);
          errs++;
        end else begin
          head = exp_q.pop_front();
          compare_rec(head, trace_rec_i);
          seen++;
        end
      end
      pend = exp_q.size();
    end
  end

endmodule

`default_nettype wire

/* core_trace_sva.sv */
`timescale 1ns/10ps
`default_nettype none

`include "trace_macros.svh"

module core_trace_sva (
  input logic                                   clk_i,
  input logic                                   reset_i,
  input logic                                   trace_v_i,
  input logic [$clog2(`TRACE_CREDITS + 1)-1:0] credit_i,
  input logic                                   overflow_i
);

  localparam int MAX_CREDITS = `TRACE_CREDITS;

  a_send_needs_credit : assert property (
    @(posedge clk_i) disable iff (reset_i) trace_v_i |-> (credit_i != '0)
  ) else $error("record presented with zero credits");

  a_credit_bound : assert property (
    @(posedge clk_i) disable iff (reset_i) int'(credit_i) <= MAX_CREDITS
  ) else $error("credit count above the sink buffer size");

  // Sticky flag only clears through reset
  a_overflow_sticky : assert property (
    @(posedge clk_i) (overflow_i && !reset_i) |=> overflow_i
  ) else $error("overflow flag fell outside reset");

endmodule

`default_nettype wire

/* tb_core_trace.sv */
`timescale 1ns/10ps
`default_nettype none

`include "trace_macros.svh"

module tb_core_trace;
  import trace_pkg::*;

  localparam int N_PLAIN    = 200;
  localparam int N_LOCAL    = 150;
  localparam int N_REMOTE   = 150;
  localparam int N_STALL    = 400;
  localparam int LONG_STALL = 300;
  localparam int N_TAIL     = 20;
  localparam int N_BP       = `TRACE_CREDITS + `TRACE_FIFO_DEPTH + 6;
  localparam int DRAIN_MAX  = 100;
  localparam int LIMIT      = 2 * (N_PLAIN + N_LOCAL + N_REMOTE + N_STALL + LONG_STALL
                                   + N_TAIL + N_BP + 8) + 5 * DRAIN_MAX;

  logic clk, reset;
  logic exe_v, lsu_v, lsu_w, remote_v, remote_w, rf_wen;
  logic [31:0] exe_pc, exe_instr, lsu_data, load_data, remote_addr, remote_data, rf_wdata;
  logic [`TRACE_LADDR_W-1:0] lsu_addr;
  logic [4:0] rf_waddr;
  logic stall_all, stall_ifetch, stall_idiv, stall_load, trace_en, credit_return;
  logic trace_v, overflow;
  trace_rec_s trace_rec;
  logic exp_v;
  trace_rec_s exp_rec;
  int err_cnt, seen_cnt, pending;

  // Mirror of the stage registers and stall counter
  logic mem_v_m, wb_v_m;
  trace_rec_s mem_m, wb_m;
  logic [`TRACE_STALLCNT_W-1:0] scnt_m;
  stall_code_e scode_m;

  logic [31:0] rng;
  logic hold_credits;
  int recv_cnt = 0;
  int sink_errs = 0;
  int ret_cnt, tb_errs, bp_budget, stall_left, cyc, err_base, seen_base, total;

  tb_clkgen u_clk (.clk_o(clk), .reset_o(reset));

  core_trace_top u_dut (
    .clk_i(clk), .reset_i(reset),
    .exe_v_i(exe_v), .exe_pc_i(exe_pc), .exe_instr_i(exe_instr),
    .lsu_v_i(lsu_v), .lsu_w_i(lsu_w), .lsu_addr_i(lsu_addr), .lsu_data_i(lsu_data),
    .load_data_i(load_data),
    .remote_v_i(remote_v), .remote_w_i(remote_w),
    .remote_addr_i(remote_addr), .remote_data_i(remote_data),
    .rf_wen_i(rf_wen), .rf_waddr_i(rf_waddr), .rf_wdata_i(rf_wdata),
    .stall_all_i(stall_all), .stall_ifetch_i(stall_ifetch),
    .stall_idiv_i(stall_idiv), .stall_load_i(stall_load),
    .trace_en_i(trace_en), .credit_return_i(credit_return),
    .trace_v_o(trace_v), .trace_rec_o(trace_rec), .trace_overflow_o(overflow)
  );

  tb_trace_checker u_chk (
    .clk_i(clk), .reset_i(reset), .trace_v_i(trace_v), .trace_rec_i(trace_rec),
    .exp_v_i(exp_v), .exp_rec_i(exp_rec),
    .err_cnt_o(err_cnt), .seen_cnt_o(seen_cnt), .pending_o(pending)
  );

  bind trace_fifo_credit core_trace_sva u_sva (
    .clk_i(clk_i), .reset_i(reset_i), .trace_v_i(trace_v_o),
    .credit_i(credit_r), .overflow_i(overflow_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // True with probability 1/n
  function automatic logic coin(input int n);
    return (rand32() % n) == 0;
  endfunction

  function automatic stall_code_e stall_reason(input logic ifetch, input logic idiv,
                                               input logic load);
    if (ifetch) return STALL_IFETCH;
    if (idiv) return STALL_IDIV;
    if (load) return STALL_LOAD;
    return STALL_OTHER;
  endfunction

  // Sink model counts records taken and flags a send into a full buffer
  always @(posedge clk) begin
    if (!reset && trace_v) begin
      if (recv_cnt - ret_cnt >= `TRACE_CREDITS) begin
        $display("record sent while the sink buffer is full");
        sink_errs++;
      end
      recv_cnt++;
    end
  end

  // One cycle from a falling edge to the next
  task automatic cycle();
    trace_rec_s ent;
    logic retire;
    credit_return = !hold_credits && (ret_cnt < recv_cnt) && !coin(4);
    if (credit_return) ret_cnt++;
    retire = wb_v_m && !stall_all && trace_en;
    exp_v = 1'b0;
    if (retire) begin
      exp_rec = wb_m;
      exp_rec.rf_wen = rf_wen;
      exp_rec.rf_waddr = rf_waddr;
      exp_rec.rf_wdata = rf_wdata;
      exp_rec.stall_code = scode_m;
      exp_rec.stall_cycles = scnt_m;
      if (bp_budget != 0) begin
        exp_v = 1'b1;
        if (bp_budget > 0) bp_budget--;
      end
      scnt_m = '0;
      scode_m = STALL_NONE;
    end else if (stall_all) begin
      if (scnt_m != '1) scnt_m = scnt_m + 1'b1;
      scode_m = stall_reason(stall_ifetch, stall_idiv, stall_load);
    end
    if (!stall_all) begin
      ent = '0;
      ent.pc = exe_pc;
      ent.instr = exe_instr;
      ent.kind = ACC_NONE;
      if (exe_v && lsu_v) begin
        ent.kind = lsu_w ? ACC_LSTORE : ACC_LLOAD;
        ent.mem.lcl.addr = lsu_addr;
        ent.mem.lcl.data = lsu_data;
      end else if (exe_v && remote_v) begin
        ent.kind = remote_w ? ACC_RSTORE : ACC_RLOAD;
        ent.mem.rmt.addr = remote_addr;
        if (remote_w) ent.mem.rmt.data = remote_data;
      end
      wb_v_m = mem_v_m;
      wb_m = mem_m;
      if (mem_m.kind == ACC_LLOAD) wb_m.mem.lcl.data = load_data;
      mem_v_m = exe_v;
      mem_m = ent;
    end
    cyc++;
    if (cyc > LIMIT) begin
      $display("timeout: run passed its limit of %0d cycles", LIMIT);
      $display("TEST FAILED");
      $finish;
    end
    @(negedge clk);
  endtask

  task automatic set_idle();
    exe_v = 1'b0;
    lsu_v = 1'b0;
    remote_v = 1'b0;
    stall_all = 1'b0;
    trace_en = 1'b1;
  endtask

  // Mode 0 plain, 1 local, 2 remote, 3 mixed, 4 back-to-back
  task automatic drive_inputs(input int mode);
    exe_v = (mode == 4) ? 1'b1 : coin(2);
    exe_pc = exe_pc + 32'd4;
    exe_instr = rand32();
    lsu_v = (mode == 1) ? !coin(5) : (mode == 3) ? coin(3) : 1'b0;
    lsu_w = coin(2);
    lsu_addr = `TRACE_LADDR_W'(rand32());
    lsu_data = rand32();
    load_data = rand32();
    remote_v = (mode == 2) ? 1'b1 : (mode == 1 || mode == 3) ? coin(2) : 1'b0;
    remote_w = coin(2);
    remote_addr = rand32();
    remote_data = rand32();
    rf_wen = coin(2);
    rf_waddr = 5'(rand32());
    rf_wdata = rand32();
    stall_all = 1'b0;
    stall_ifetch = 1'b0;
    stall_idiv = 1'b0;
    stall_load = 1'b0;
    trace_en = 1'b1;
  endtask

  task automatic step(input int mode);
    drive_inputs(mode);
    cycle();
  endtask

  task automatic stall_step(input logic force_stall);
    drive_inputs(3);
    if (stall_left == 0 && coin(5)) begin
      stall_left = 1 + int'(rand32() % 32'd12);
    end
    stall_all = force_stall || (stall_left != 0);
    if (stall_left != 0) stall_left--;
    stall_ifetch = coin(3);
    stall_idiv = coin(3);
    stall_load = coin(3);
    trace_en = force_stall || !coin(6);
    cycle();
  endtask

  task automatic drain();
    int n;
    n = 0;
    set_idle();
    while (n < 4 || pending != 0 || ret_cnt != recv_cnt) begin
      cycle();
      n++;
    end
  endtask

  task automatic end_test(input string name, input logic want_overflow);
    int errs;
    drain();
    if (overflow !== want_overflow) begin
      $display("overflow flag is %0b after %s, expected %0b", overflow, name, want_overflow);
      tb_errs++;
    end
    errs = err_cnt + tb_errs + sink_errs;
    $display("%s: %0d records, %0d errors", name, seen_cnt - seen_base, errs - err_base);
    err_base = errs;
    seen_base = seen_cnt;
  endtask

  initial begin
    rng = 32'd93901;
    exe_pc = 32'h0000_1000;
    exe_instr = '0;
    lsu_w = 1'b0;
    lsu_addr = '0;
    lsu_data = '0;
    load_data = '0;
    remote_w = 1'b0;
    remote_addr = '0;
    remote_data = '0;
    rf_wen = 1'b0;
    rf_waddr = '0;
    rf_wdata = '0;
    stall_ifetch = 1'b0;
    stall_idiv = 1'b0;
    stall_load = 1'b0;
    credit_return = 1'b0;
    set_idle();
    exp_v = 1'b0;
    exp_rec = '0;
    mem_v_m = 1'b0;
    wb_v_m = 1'b0;
    mem_m = '0;
    wb_m = '0;
    scnt_m = '0;
    scode_m = STALL_NONE;
    hold_credits = 1'b0;
    bp_budget = -1;
    ret_cnt = 0;
    tb_errs = 0;
    stall_left = 0;
    cyc = 0;
    err_base = 0;
    seen_base = 0;
    repeat (2) @(negedge clk);
    while (reset) @(negedge clk);

    repeat (N_PLAIN) step(0);
    end_test("stall-free retirement", 1'b0);
    repeat (N_LOCAL) step(1);
    end_test("local accesses", 1'b0);
    repeat (N_REMOTE) step(2);
    end_test("remote accesses", 1'b0);

    repeat (N_STALL) stall_step(1'b0);
    // Long enough to saturate the counter
    repeat (LONG_STALL) stall_step(1'b1);
    repeat (N_TAIL) step(0);
    end_test("stalls and trace enable", 1'b0);

    hold_credits = 1'b1;
    bp_budget = `TRACE_CREDITS + `TRACE_FIFO_DEPTH;
    repeat (N_BP) step(4);
    set_idle();
    repeat (8) cycle();
    if (seen_cnt - seen_base != `TRACE_CREDITS) begin
      $display("%0d records sent with credits held, expected %0d",
               seen_cnt - seen_base, `TRACE_CREDITS);
      tb_errs++;
    end
    hold_credits = 1'b0;
    end_test("back-pressure", 1'b1);

    total = err_cnt + tb_errs + sink_errs;
    $display("summary: 5 tests, %0d records checked, %0d errors", seen_cnt, total);
    if (total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
trace_pkg.sv
wb_stage_if.sv
trace_stage_pipe.sv
trace_encoder.sv
trace_fifo_credit.sv
core_trace_top.sv
tb_clkgen.sv
tb_trace_checker.sv
core_trace_sva.sv
tb_core_trace.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_core_trace
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing
SIM       ?= $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
